// ==== rtl/tinker_pkg.sv ====
/*
 Shared types and constants for the Tinker five-stage core.
 Instruction memory spans reset_pc .. reset_pc + 4*imem_words (byte addresses).
 No floating point, no call/return, no mov rd, L.
*/
`default_nettype none

package tinker_pkg;

    localparam int xlen       = 64;
    localparam int addr_w     = 32;
    localparam int imem_words = 1024;
    localparam int imem_aw    = $clog2(imem_words);
    localparam int num_regs   = 32;

    typedef logic [xlen-1:0] word_t;

    localparam word_t reset_pc = 64'h2000;  // First fetch address

    // ------------------------------
    // Opcodes, Tinker encoding
    // ------------------------------
    typedef enum logic [4:0] {
        op_add   = 5'b11000, op_addi  = 5'b11001,
        op_sub   = 5'b11010, op_subi  = 5'b11011,
        op_mul   = 5'b11100, op_div   = 5'b11101,
        op_and   = 5'b00000, op_or    = 5'b00001,
        op_xor   = 5'b00010, op_not   = 5'b00011,
        op_shr   = 5'b00100, op_shri  = 5'b00101,
        op_shl   = 5'b00110, op_shli  = 5'b00111,
        op_mov   = 5'b10001, op_load  = 5'b10000, op_store = 5'b10011,
        op_jmp   = 5'b01000, op_jmpr  = 5'b01001, op_jmpri = 5'b01010,
        op_brnz  = 5'b01011, op_brgt  = 5'b01110,
        op_priv  = 5'b01111
    } opcode_e;

    typedef struct packed {
        logic [4:0]  op;   // Bits 31..27
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [11:0] lit;  // Bits 11..0
    } instr_t;

    // ------------------------------
    // Pipeline payloads
    // ------------------------------
    typedef struct packed {
        logic       valid;
        opcode_e    op;
        logic [4:0] rd;
        word_t      pc;
        word_t      val1;
        word_t      val2;    // Literal already merged in
        word_t      rd_val;
        logic       is_load;
        logic       is_halt;
    } idex_t;

    typedef struct packed {
        logic              valid;
        logic [4:0]        rd;
        word_t             result;
        logic              reg_we;
        logic              is_load;
        logic              is_halt;
        logic              mem_we;
        logic [addr_w-1:0] mem_addr;
        word_t             mem_wdata;
    } exmem_t;

    typedef struct packed {
        logic              rd_en;
        logic              wr_en;
        logic [addr_w-1:0] addr;
        word_t             wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

// ==== rtl/tinker_fetch.sv ====
/*
 Fetch stage with PC, instruction memory and IF/ID register.
 prog_addr is a byte address in the PC space; load only while run is low.
 Addresses outside the memory window wrap onto it.
*/
`timescale 1ns/1ps
`default_nettype none

module tinker_fetch (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        run,
    input  logic                        prog_we,
    input  logic [tinker_pkg::addr_w-1:0] prog_addr,
    input  tinker_pkg::instr_t          prog_data,
    input  logic                        redirect,
    input  tinker_pkg::word_t           redirect_pc,
    input  logic                        halt_seen,
    output tinker_pkg::instr_t          if_instr,
    output tinker_pkg::word_t           if_pc,
    output logic                        if_valid
);
    import tinker_pkg::*;

    instr_t              imem [imem_words];
    word_t               pc;
    word_t               pc_off;
    logic [addr_w-1:0]   prog_off;
    logic [imem_aw-1:0]  fetch_idx;
    logic [imem_aw-1:0]  load_idx;
    logic                advance;

    assign pc_off    = pc - reset_pc;
    assign fetch_idx = pc_off[imem_aw+1:2];           // Word index
    assign prog_off  = prog_addr - addr_w'(reset_pc);
    assign load_idx  = prog_off[imem_aw+1:2];
    assign advance   = run && !halt_seen;

    always_ff @(posedge clk) begin
        if (prog_we)
            imem[load_idx] <= prog_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= reset_pc;
            if_valid <= 1'b0;
        end else begin
            if (redirect)
                pc <= redirect_pc;    // Branch wins over sequential
            else if (advance)
                pc <= pc + 64'd4;
            if_valid <= advance;
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (advance) begin
            if_instr <= imem[fetch_idx];
            if_pc    <= pc;
        end
    end

    a_no_load_while_running: assert property (@(posedge clk) disable iff (reset)
        !(prog_we && run)) else $error("Program write while core is running");

endmodule

`default_nettype wire

// ==== rtl/tinker_regfile.sv ====
/*
 32 x 64-bit register file, cleared by reset.
 Reads are combinational; no write-through to the decode reads.
*/
`timescale 1ns/1ps
`default_nettype none

module tinker_regfile (
    input  logic              clk,
    input  logic              reset,
    input  logic [4:0]        rs,
    input  logic [4:0]        rt,
    input  logic [4:0]        rd,
    output tinker_pkg::word_t rs_val,
    output tinker_pkg::word_t rt_val,
    output tinker_pkg::word_t rd_val,
    input  logic              wb_we,
    input  logic [4:0]        wb_rd,
    input  tinker_pkg::word_t wb_data
);
    import tinker_pkg::*;

    word_t regs [num_regs];

    assign rs_val = regs[rs];
    assign rt_val = regs[rt];
    assign rd_val = regs[rd];  // Base for store, jump target

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tinker_decode.sv ====
/*
 Decode stage and ID/EX register.
 priv with a zero literal halts; any other literal is a no-op.
 halt_seen stops fetch in the same cycle the halt sits in decode.
*/
`timescale 1ns/1ps
`default_nettype none

module tinker_decode (
    input  logic               clk,
    input  logic               reset,
    input  tinker_pkg::instr_t if_instr,
    input  tinker_pkg::word_t  if_pc,
    input  logic               if_valid,
    output logic [4:0]         rs,
    output logic [4:0]         rt,
    output logic [4:0]         rd,
    input  tinker_pkg::word_t  rs_val,
    input  tinker_pkg::word_t  rt_val,
    input  tinker_pkg::word_t  rd_val,
    output tinker_pkg::idex_t  idex,
    output logic               halt_seen
);
    import tinker_pkg::*;

    opcode_e op;
    word_t   lit_ext;
    logic    uses_lit;
    logic    halt_now;
    logic    halt_q;

    assign op      = opcode_e'(if_instr.op);
    assign rs      = if_instr.rs;
    assign rt      = if_instr.rt;
    assign rd      = if_instr.rd;
    assign lit_ext = {{(xlen-12){if_instr.lit[11]}}, if_instr.lit};

    // Literal forms take the 12-bit immediate in place of rt
    assign uses_lit = op inside {op_addi, op_subi, op_shri, op_shli,
                                 op_jmpri, op_load, op_store};

    assign halt_now  = if_valid && (op == op_priv) && (if_instr.lit == 12'd0);
    assign halt_seen = halt_q || halt_now;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex   <= '0;
            halt_q <= 1'b0;
        end else begin
            idex.valid   <= if_valid;
            idex.op      <= op;
            idex.rd      <= if_instr.rd;
            idex.pc      <= if_pc;
            idex.val1    <= rs_val;
            idex.val2    <= uses_lit ? lit_ext : rt_val;
            idex.rd_val  <= rd_val;
            idex.is_load <= if_valid && (op == op_load);
            idex.is_halt <= halt_now;
            halt_q       <= halt_q || halt_now;  // Sticky until reset
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tinker_execute.sv ====
/*
 Execute stage with ALU, address generation, branch decision and EX/MEM register.
 redirect is registered here, so a taken branch runs three delay slots.
 div by zero gives whatever the divider returns.
*/
`timescale 1ns/1ps
`default_nettype none

module tinker_execute (
    input  logic                clk,
    input  logic                reset,
    input  tinker_pkg::idex_t   idex,
    output tinker_pkg::exmem_t  exmem,
    output logic                redirect,
    output tinker_pkg::word_t   redirect_pc
);
    import tinker_pkg::*;

    word_t             result;
    logic              reg_we;
    logic              mem_we;
    logic              take;
    word_t             target;
    word_t             ld_ea;
    word_t             st_ea;
    logic [addr_w-1:0] mem_addr;

    assign ld_ea    = idex.val1 + idex.val2;
    assign st_ea    = idex.rd_val + idex.val2;
    assign mem_addr = mem_we ? st_ea[addr_w-1:0] : ld_ea[addr_w-1:0];

    // ------------------------------
    // ALU and branch decision
    // ------------------------------
    always_comb begin
        result = '0;
        reg_we = 1'b0;
        mem_we = 1'b0;
        take   = 1'b0;
        target = idex.rd_val;
        case (idex.op)
            op_add, op_addi: begin
                result = idex.val1 + idex.val2;
                reg_we = 1'b1;
            end
            op_sub, op_subi: begin
                result = idex.val1 - idex.val2;
                reg_we = 1'b1;
            end
            op_mul: begin result = idex.val1 * idex.val2; reg_we = 1'b1; end
            op_div: begin result = idex.val1 / idex.val2; reg_we = 1'b1; end
            op_and: begin result = idex.val1 & idex.val2; reg_we = 1'b1; end
            op_or:  begin result = idex.val1 | idex.val2; reg_we = 1'b1; end
            op_xor: begin result = idex.val1 ^ idex.val2; reg_we = 1'b1; end
            op_not: begin result = ~idex.val1;            reg_we = 1'b1; end
            op_shr, op_shri: begin
                result = idex.val1 >> idex.val2;
                reg_we = 1'b1;
            end
            op_shl, op_shli: begin
                result = idex.val1 << idex.val2;
                reg_we = 1'b1;
            end
            op_mov:   begin result = idex.val1; reg_we = 1'b1; end
            op_load:  reg_we = 1'b1;             // Data comes from memory in WB
            op_store: mem_we = 1'b1;
            op_jmp:   take = 1'b1;
            op_jmpr: begin
                take   = 1'b1;
                target = idex.pc + idex.rd_val;
            end
            op_jmpri: begin
                take   = 1'b1;
                target = idex.pc + idex.val2;    // val2 holds the literal
            end
            op_brnz: take = (idex.val1 != '0);
            op_brgt: take = ($signed(idex.val1) > $signed(idex.val2));
            default: ;                           // priv and unknown do nothing
        endcase
    end

    // ------------------------------
    // EX/MEM register
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem       <= '0;
            redirect    <= 1'b0;
            redirect_pc <= '0;
        end else begin
            exmem.valid     <= idex.valid;
            exmem.rd        <= idex.rd;
            exmem.result    <= result;
            exmem.reg_we    <= idex.valid && reg_we;
            exmem.is_load   <= idex.valid && idex.is_load;
            exmem.is_halt   <= idex.valid && idex.is_halt;
            exmem.mem_we    <= idex.valid && mem_we;
            exmem.mem_addr  <= mem_addr;
            exmem.mem_wdata <= idex.val1;        // Store data from rs
            redirect        <= idex.valid && take;
            redirect_pc     <= target;
        end
    end

    a_we_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(exmem.mem_we && exmem.reg_we)) else $error("Store and register write together");

endmodule

`default_nettype wire

// ==== rtl/tinker_mem_wb.sv ====
/*
 Memory stage and MEM/WB register.
 Data memory must return dmem_rdata in the same cycle as the request.
 hlt stays high until reset.
*/
`timescale 1ns/1ps
`default_nettype none

module tinker_mem_wb (
    input  logic                   clk,
    input  logic                   reset,
    input  tinker_pkg::exmem_t     exmem,
    output tinker_pkg::dmem_req_t  dmem_req,
    input  tinker_pkg::word_t      dmem_rdata,
    output logic                   wb_we,
    output logic [4:0]             wb_rd,
    output tinker_pkg::word_t      wb_data,
    output logic                   hlt
);
    import tinker_pkg::*;

    logic  load_q;
    word_t result_q;
    word_t ldata_q;

    always_comb begin
        dmem_req.rd_en = exmem.valid && exmem.is_load;
        dmem_req.wr_en = exmem.mem_we;
        dmem_req.addr  = exmem.mem_addr;
        dmem_req.wdata = exmem.mem_wdata;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_we  <= 1'b0;
            load_q <= 1'b0;
            hlt    <= 1'b0;
        end else begin
            wb_we  <= exmem.reg_we;
            load_q <= exmem.is_load;
            hlt    <= hlt || exmem.is_halt;
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        wb_rd    <= exmem.rd;
        result_q <= exmem.result;
        ldata_q  <= dmem_rdata;
    end

    assign wb_data = load_q ? ldata_q : result_q;

    // Nothing behind the halt may reach memory
    a_no_store_after_halt: assert property (@(posedge clk) disable iff (reset)
        hlt |-> !dmem_req.wr_en) else $error("Store issued after halt");

endmodule

`default_nettype wire

// ==== rtl/tinker_core.sv ====
/*
 Tinker five-stage core top level.
 No hazard detection and no forwarding. A result is visible to the fourth
 following instruction, and a taken branch executes three delay slots.
*/
`timescale 1ns/1ps
`default_nettype none

module tinker_core (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          prog_we,
    input  logic [tinker_pkg::addr_w-1:0] prog_addr,
    input  tinker_pkg::instr_t            prog_data,
    output tinker_pkg::dmem_req_t         dmem_req,
    input  tinker_pkg::word_t             dmem_rdata,
    output logic                          hlt
);
    import tinker_pkg::*;

    instr_t     if_instr;
    word_t      if_pc;
    logic       if_valid;
    logic [4:0] rs, rt, rd;
    word_t      rs_val, rt_val, rd_val;
    idex_t      idex;
    logic       halt_seen;
    exmem_t     exmem;
    logic       redirect;
    word_t      redirect_pc;
    logic       wb_we;
    logic [4:0] wb_rd;
    word_t      wb_data;

    tinker_fetch i_fetch (
        .clk, .reset, .run, .prog_we, .prog_addr, .prog_data,
        .redirect, .redirect_pc, .halt_seen,
        .if_instr, .if_pc, .if_valid
    );

    tinker_regfile i_regfile (
        .clk, .reset, .rs, .rt, .rd, .rs_val, .rt_val, .rd_val,
        .wb_we, .wb_rd, .wb_data
    );

    tinker_decode i_decode (
        .clk, .reset, .if_instr, .if_pc, .if_valid,
        .rs, .rt, .rd, .rs_val, .rt_val, .rd_val,
        .idex, .halt_seen
    );

    tinker_execute i_execute (
        .clk, .reset, .idex, .exmem, .redirect, .redirect_pc
    );

    tinker_mem_wb i_mem_wb (
        .clk, .reset, .exmem, .dmem_req, .dmem_rdata,
        .wb_we, .wb_rd, .wb_data, .hlt
    );

endmodule

`default_nettype wire

// ==== tests/tinker_tb_cases.svh ====
/*
 Case table with name, opcode, a, b and expected value.
 a and b are loaded with addi, so both must fit a 12-bit signed literal.
 ALU cases expect the word stored at 0x100, load_mov expects a, and
 branch cases expect 1 when the marker store at 0x300 must appear.
*/
`ifndef TINKER_TB_CASES_SVH
`define TINKER_TB_CASES_SVH

function automatic void load_case_table();
    add_case("add",        op_add,     100,    23, 64'd123);
    add_case("addi_neg",   op_addi,     50,   -75, -64'd25);
    add_case("sub",        op_sub,      10,   300, -64'd290);
    add_case("subi_neg",   op_subi,     -7,   -20, 64'd13);
    add_case("mul_neg",    op_mul,      -3,     7, -64'd21);
    add_case("div",        op_div,    2000,     7, 64'd285);
    add_case("and",        op_and,   'h5a3, 'h3cf, 64'h183);
    add_case("or",         op_or,    'h5a3, 'h3cf, 64'h7ef);
    add_case("xor",        op_xor,   'h5a3, 'h3cf, 64'h66c);
    add_case("not",        op_not,   'h0f0,     0, 64'hffff_ffff_ffff_ff0f);
    add_case("shr",        op_shr,    1536,     4, 64'd96);
    add_case("shri",       op_shri,    -16,     2, 64'h3fff_ffff_ffff_fffc);
    add_case("shl",        op_shl,       3,    10, 64'd3072);
    add_case("shli",       op_shli,     -1,    60, 64'hf000_0000_0000_0000);
    add_case("load_mov",   op_load,  -1234,     0, -64'd1234);
    add_case("brnz_taken", op_brnz,      7,     0, 64'd0);
    add_case("brnz_fall",  op_brnz,      0,     0, 64'd1);
    add_case("brgt_taken", op_brgt,      3,    -5, 64'd0);   // Signed compare
    add_case("brgt_neg",   op_brgt,     -1,    -5, 64'd0);
    add_case("brgt_fall",  op_brgt,     -5,     3, 64'd1);
    add_case("jmpri",      op_jmpri,     0,     0, 64'd0);
endfunction

`endif

// ==== tests/tinker_tb.sv ====
/*
 Testbench for the Tinker core. Each table case runs as a small program.
 Data memory is an associative array that answers in the same cycle.
 Programs pad register hazards and branch delay slots with no-ops.
*/
`timescale 1ns/1ps
`default_nettype none

module tinker_tb;
    import tinker_pkg::*;

    localparam int clk_period   = 100;
    localparam int hlt_limit    = 64;     // Cycles allowed per program
    localparam int margin_ticks = 200;
    localparam int res_addr     = 'h100;
    localparam int save_addr    = 'h200;
    localparam int marker_addr  = 'h300;
    localparam int branch_at    = 12;     // Index of the branch
    localparam int target_at    = 17;     // Index of the halt

    logic              clk = 1'b0;
    logic              reset;
    logic              run;
    logic              prog_we;
    logic [addr_w-1:0] prog_addr;
    instr_t            prog_data;
    dmem_req_t         dmem_req;
    word_t             dmem_rdata;
    logic              hlt;
    logic              hlt_prev = 1'b0;

    word_t   dmem [logic [addr_w-1:0]];
    instr_t  prog [$];
    string   case_name [$];
    opcode_e case_op [$];
    int      case_a [$];
    int      case_b [$];
    word_t   case_exp [$];
    int      check_errors = 0;
    int      monitor_errors = 0;
    int      passed = 0;
    int      failed = 0;

    tinker_core i_dut (
        .clk, .reset, .run, .prog_we, .prog_addr, .prog_data,
        .dmem_req, .dmem_rdata, .hlt
    );

    always #(clk_period / 2) clk = ~clk;

    // ------------------------------
    // Data memory model
    // ------------------------------
    always_comb begin
        dmem_rdata = '0;
        if (dmem_req.rd_en && dmem.exists(dmem_req.addr))
            dmem_rdata = dmem[dmem_req.addr];
    end

    always @(posedge clk) begin
        if (reset)
            dmem.delete();                        // Fresh memory per case
        else if (dmem_req.wr_en)
            dmem[dmem_req.addr] = dmem_req.wdata;
    end

    // Halt behavior on every edge
    always @(posedge clk) begin
        if (!reset) begin
            assert (!(hlt && dmem_req.wr_en)) else begin
                $display("A store request was issued after hlt at %0t", $time);
                monitor_errors++;
            end
            assert (!(hlt_prev && !hlt)) else begin
                $display("hlt fell without a reset at %0t", $time);
                monitor_errors++;
            end
        end
        hlt_prev <= hlt && !reset;
    end

    function automatic void add_case(string name, opcode_e op, int a, int b, word_t exp);
        case_name.push_back(name);
        case_op.push_back(op);
        case_a.push_back(a);
        case_b.push_back(b);
        case_exp.push_back(exp);
    endfunction

    `include "tinker_tb_cases.svh"

    // ------------------------------
    // Program builder
    // ------------------------------
    function automatic instr_t encode(opcode_e op, int rd, int rs, int rt, int lit);
        instr_t ins;
        ins.op  = op;
        ins.rd  = rd[4:0];
        ins.rs  = rs[4:0];
        ins.rt  = rt[4:0];
        ins.lit = lit[11:0];
        return ins;
    endfunction

    function automatic void pad_nops(int n);
        repeat (n) prog.push_back(encode(op_priv, 0, 0, 0, 1));  // priv 1 is a no-op
    endfunction

    function automatic void build_program(opcode_e op, int a, int b);
        prog.delete();
        if (op inside {op_brnz, op_brgt, op_jmpri}) begin
            prog.push_back(encode(op_addi, 5, 0, 0, int'(reset_pc >> 3)));
            prog.push_back(encode(op_addi, 1, 0, 0, a));
            prog.push_back(encode(op_addi, 2, 0, 0, b));
            pad_nops(1);
            prog.push_back(encode(op_shli, 5, 5, 0, 3));          // r5 = reset_pc
            pad_nops(3);
            prog.push_back(encode(op_addi, 5, 5, 0, 4 * target_at));
            pad_nops(3);
            if (op == op_brnz)
                prog.push_back(encode(op_brnz, 5, 1, 0, 0));
            else if (op == op_brgt)
                prog.push_back(encode(op_brgt, 5, 1, 2, 0));
            else
                prog.push_back(encode(op_jmpri, 0, 0, 0, 4 * (target_at - branch_at)));
            pad_nops(2);
            prog.push_back(encode(op_store, 0, 1, 0, res_addr));  // Last delay slot
            prog.push_back(encode(op_store, 0, 1, 0, marker_addr));
        end else begin
            prog.push_back(encode(op_addi, 1, 0, 0, a));
            prog.push_back(encode(op_addi, 2, 0, 0, b));
            pad_nops(3);
            if (op == op_load) begin
                prog.push_back(encode(op_store, 0, 1, 0, save_addr));
                prog.push_back(encode(op_load, 4, 0, 0, save_addr));
                pad_nops(3);
                prog.push_back(encode(op_mov, 3, 4, 0, 0));
            end else if (op inside {op_addi, op_subi, op_shri, op_shli}) begin
                prog.push_back(encode(op, 3, 1, 0, b));
            end else begin
                prog.push_back(encode(op, 3, 1, 2, 0));
            end
            pad_nops(3);
            prog.push_back(encode(op_store, 0, 3, 0, res_addr));
        end
        prog.push_back(encode(op_priv, 0, 0, 0, 0));              // Halt
        prog.push_back(encode(op_store, 0, 1, 0, marker_addr));   // Store behind the halt
    endfunction

    // ------------------------------
    // Per-case sequence and checks
    // ------------------------------
    task automatic check_word(string name, int addr, word_t exp);
        assert (dmem.exists(addr)) else begin
            $display("%s: no store reached address 0x%0h", name, addr);
            check_errors++;
        end
        if (dmem.exists(addr)) begin
            assert (dmem[addr] == exp) else begin
                $display("Mismatch %s expected 0x%h actual 0x%h", name, exp, dmem[addr]);
                check_errors++;
            end
        end
    endtask

    task automatic run_case(int i);
        int  base;
        bit  seen;
        bit  marker;
        base = check_errors + monitor_errors;
        seen = 1'b0;
        build_program(case_op[i], case_a[i], case_b[i]);
        @(posedge clk);
        reset   <= 1'b1;
        run     <= 1'b0;
        prog_we <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        foreach (prog[k]) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= addr_w'(reset_pc) + addr_w'(4 * k);
            prog_data <= prog[k];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        run     <= 1'b1;
        for (int n = 0; n < hlt_limit && !seen; n++) begin
            @(posedge clk);
            seen = hlt;
        end
        assert (seen) else begin
            $display("%s: hlt did not rise within %0d cycles", case_name[i], hlt_limit);
            check_errors++;
        end
        repeat (4) @(posedge clk);                 // hlt must hold and no store may follow
        if (case_op[i] inside {op_brnz, op_brgt, op_jmpri}) begin
            check_word(case_name[i], res_addr, word_t'(longint'(case_a[i])));
            marker = dmem.exists(marker_addr) != 0;
            assert (marker == (case_exp[i] != '0)) else begin
                $display("Mismatch %s expected %0d actual %0d", case_name[i],
                         case_exp[i] != '0, marker);
                check_errors++;
            end
        end else begin
            check_word(case_name[i], res_addr, case_exp[i]);
        end
        if (check_errors + monitor_errors == base) begin
            passed++;
            $display("PASS %s", case_name[i]);
        end else begin
            failed++;
            $display("FAIL %s", case_name[i]);
        end
    endtask

    initial begin
        reset     <= 1'b1;
        run       <= 1'b0;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        load_case_table();
        foreach (case_name[i])
            run_case(i);
        $display("Tests: %0d, passed: %0d, failed: %0d, errors: %0d",
                 case_name.size(), passed, failed, check_errors + monitor_errors);
        if (failed == 0 && check_errors == 0 && monitor_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Watchdog sized from the case count
    initial begin
        #1;
        #((case_name.size() * 40 + margin_ticks) * clk_period);
        $display("Timeout: the test sequence did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+tests
rtl/tinker_pkg.sv
rtl/tinker_fetch.sv
rtl/tinker_regfile.sv
rtl/tinker_decode.sv
rtl/tinker_execute.sv
rtl/tinker_mem_wb.sv
rtl/tinker_core.sv
tests/tinker_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the Tinker core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -f files.f --top-module tinker_tb -o tinker_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tinker_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$log"; then
    exit 0
fi
exit 1
